//--- hw/ex_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage package: widths, opcode and funct codes,
// alu and unit selectors, instruction word formats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ex_pkg;

    localparam int XLEN     = 64;
    localparam int WLEN     = 32;
    localparam int ILEN     = 32;
    localparam int SHAMT_W  = 6;
    localparam int SHAMTW_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;
    localparam logic [2:0] F3_LD_RSVD = 3'b111; // no such load in rv64i

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        UNIT_ALU, UNIT_LOAD, UNIT_STORE, UNIT_BRANCH, UNIT_NONE
    } unit_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
    } inst_u;

endpackage

`default_nettype wire

//--- hw/ex_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer alu, 64-bit ops and sign-extended 32-bit word ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_op_e          op_i,
    input  logic                     word_i,
    input  logic [ex_pkg::XLEN-1:0]  a_i,
    input  logic [ex_pkg::XLEN-1:0]  b_i,
    output logic [ex_pkg::XLEN-1:0]  result_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]     res64;
    logic [WLEN-1:0]     res32;
    logic [SHAMT_W-1:0]  shamt;
    logic [SHAMTW_W-1:0] shamt_w;
    logic [WLEN-1:0]     a32;
    logic [WLEN-1:0]     b32;

    assign shamt   = b_i[SHAMT_W-1:0];
    assign shamt_w = b_i[SHAMTW_W-1:0];
    assign a32     = a_i[WLEN-1:0];
    assign b32     = b_i[WLEN-1:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  res64 = a_i + b_i;
            ALU_SUB:  res64 = a_i - b_i;
            ALU_SLL:  res64 = a_i << shamt;
            ALU_SLT:  res64 = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: res64 = {{(XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:  res64 = a_i ^ b_i;
            ALU_SRL:  res64 = a_i >> shamt;
            ALU_SRA:  res64 = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   res64 = a_i | b_i;
            ALU_AND:  res64 = a_i & b_i;
            default:  res64 = '0;
        endcase
    end

    // word forms, shift amount from 5 bits
    always_comb begin
        case (op_i)
            ALU_ADD: res32 = a32 + b32;
            ALU_SUB: res32 = a32 - b32;
            ALU_SLL: res32 = a32 << shamt_w;
            ALU_SRL: res32 = a32 >> shamt_w;
            ALU_SRA: res32 = $unsigned($signed(a32) >>> shamt_w);
            default: res32 = res64[WLEN-1:0];
        endcase
    end

    assign result_o = word_i ? {{(XLEN-WLEN){res32[WLEN-1]}}, res32} : res64;

endmodule

`default_nettype wire

//--- hw/ex_branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// conditional branch compare and target address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  logic [2:0]               funct3_i,
    input  logic [ex_pkg::XLEN-1:0]  a_i,
    input  logic [ex_pkg::XLEN-1:0]  b_i,
    input  logic [ex_pkg::XLEN-1:0]  pc_i,
    input  logic [ex_pkg::XLEN-1:0]  offset_i,
    output logic                     taken_o,
    output logic [ex_pkg::XLEN-1:0]  target_o
);
    import ex_pkg::*;

    logic cond;
    logic legal;

    always_comb begin
        legal = 1'b1;
        case (funct3_i)
            F3_BEQ, F3_BNE:   cond = (a_i == b_i);
            F3_BLT, F3_BGE:   cond = $signed(a_i) < $signed(b_i);
            F3_BLTU, F3_BGEU: cond = a_i < b_i;
            default: begin
                cond  = 1'b0;
                legal = 1'b0;
            end
        endcase
    end

    assign taken_o  = legal & (cond ^ funct3_i[0]); // odd funct3 inverts
    assign target_o = taken_o ? pc_i + offset_i : '0;

endmodule

`default_nettype wire

//--- hw/ex_mem_agu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store address and store data formatting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_mem_agu (
    input  logic [ex_pkg::XLEN-1:0]  base_i,
    input  logic [ex_pkg::XLEN-1:0]  offset_i,
    input  logic [2:0]               funct3_i,
    input  logic [ex_pkg::XLEN-1:0]  store_data_i,
    output logic [ex_pkg::XLEN-1:0]  addr_o,
    output logic [ex_pkg::XLEN-1:0]  wdata_o
);
    import ex_pkg::*;

    assign addr_o = base_i + offset_i;

    // zero-extend by store size
    always_comb begin
        case (funct3_i)
            F3_SB:   wdata_o = {{(XLEN-8){1'b0}}, store_data_i[7:0]};
            F3_SH:   wdata_o = {{(XLEN-16){1'b0}}, store_data_i[15:0]};
            F3_SW:   wdata_o = {{(XLEN-32){1'b0}}, store_data_i[31:0]};
            F3_SD:   wdata_o = store_data_i;
            default: wdata_o = store_data_i; // not a store size
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage: unit and alu op select, offsets, operand
// registers for the execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_decode (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     valid_i,
    input  logic [ex_pkg::ILEN-1:0]  inst_i,
    input  logic [ex_pkg::XLEN-1:0]  pc_i,
    input  logic [ex_pkg::XLEN-1:0]  op1_i,
    input  logic [ex_pkg::XLEN-1:0]  op2_i,
    input  logic [ex_pkg::XLEN-1:0]  rs2_data_i,
    output logic                     d_valid_o,
    output ex_pkg::unit_e            d_unit_o,
    output ex_pkg::alu_op_e          d_alu_op_o,
    output logic                     d_word_o,
    output logic [2:0]               d_funct3_o,
    output logic [4:0]               d_rd_o,
    output logic [ex_pkg::XLEN-1:0]  d_op1_o,
    output logic [ex_pkg::XLEN-1:0]  d_op2_o,
    output logic [ex_pkg::XLEN-1:0]  d_store_data_o,
    output logic [ex_pkg::XLEN-1:0]  d_pc_o,
    output logic [ex_pkg::XLEN-1:0]  d_offset_o
);
    import ex_pkg::*;

    inst_u           inst;
    logic [2:0]      f3;
    logic            f7_ok;
    logic            shift_imm;
    unit_e           unit;
    alu_op_e         alu_op;
    logic            word;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] offset;

    // funct3 plus bit 30 to alu op, word forms only have add/sub/shifts
    function automatic alu_op_e map_op(input logic [2:0] fn3, input logic alt,
                                       input logic w);
        case (fn3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return alt ? ALU_NONE : ALU_SLL;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_SLT:  return (alt || w) ? ALU_NONE : ALU_SLT;
            F3_SLTU: return (alt || w) ? ALU_NONE : ALU_SLTU;
            F3_XOR:  return (alt || w) ? ALU_NONE : ALU_XOR;
            F3_OR:   return (alt || w) ? ALU_NONE : ALU_OR;
            default: return (alt || w) ? ALU_NONE : ALU_AND;
        endcase
    endfunction

    assign inst      = inst_i;
    assign f3        = inst.r.funct3;
    assign f7_ok     = (inst.r.funct7 == F7_BASE) || (inst.r.funct7 == F7_ALT);
    assign shift_imm = (f3 == F3_SLL) || (f3 == F3_SR);

    always_comb begin
        unit   = UNIT_NONE;
        alu_op = ALU_NONE;
        word   = 1'b0;
        op2    = op2_i;
        case (inst.r.opcode)
            OPC_OP, OPC_OP_32: begin
                word   = (inst.r.opcode == OPC_OP_32);
                alu_op = f7_ok ? map_op(f3, inst_i[30], word) : ALU_NONE;
            end
            OPC_OP_IMM: begin
                if (shift_imm) begin // rv64 shamt is 6 bits, funct6 above it
                    op2 = {{(XLEN-SHAMT_W){1'b0}}, inst.i.imm[SHAMT_W-1:0]};
                    if (inst.i.imm[11:6] == F7_BASE[6:1] || inst.i.imm[11:6] == F7_ALT[6:1])
                        alu_op = map_op(f3, inst_i[30], 1'b0);
                end else begin
                    alu_op = map_op(f3, 1'b0, 1'b0);
                end
            end
            OPC_OP_IMM_32: begin
                word = 1'b1;
                if (shift_imm) begin
                    op2    = {{(XLEN-SHAMTW_W){1'b0}}, inst.i.imm[SHAMTW_W-1:0]};
                    alu_op = f7_ok ? map_op(f3, inst_i[30], 1'b1) : ALU_NONE;
                end else begin
                    alu_op = map_op(f3, 1'b0, 1'b1); // only addiw survives
                end
            end
            OPC_LOAD:   unit = (f3 != F3_LD_RSVD) ? UNIT_LOAD : UNIT_NONE;
            OPC_STORE:  unit = (f3[2] == 1'b0) ? UNIT_STORE : UNIT_NONE;
            OPC_BRANCH: unit = (f3[2:1] != 2'b01) ? UNIT_BRANCH : UNIT_NONE;
            default:    unit = UNIT_NONE;
        endcase
        if (alu_op != ALU_NONE)
            unit = UNIT_ALU;
    end

    // s or b immediate, b keeps the implied zero lsb
    assign offset = (inst.r.opcode == OPC_BRANCH) ?
        {{(XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0} :
        {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

    always_ff @(posedge clk) begin
        if (reset_i)
            d_valid_o <= 1'b0;
        else
            d_valid_o <= valid_i;
    end

    always_ff @(posedge clk) begin
        d_unit_o       <= unit;
        d_alu_op_o     <= alu_op;
        d_word_o       <= word;
        d_funct3_o     <= f3;
        d_rd_o         <= inst.r.rd;
        d_op1_o        <= op1_i;
        d_op2_o        <= op2;
        d_store_data_o <= rs2_data_i;
        d_pc_o         <= pc_i;
        d_offset_o     <= offset;
    end

endmodule

`default_nettype wire

//--- hw/ex_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: alu, branch unit, agu, result registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_execute (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     d_valid_i,
    input  ex_pkg::unit_e            d_unit_i,
    input  ex_pkg::alu_op_e          d_alu_op_i,
    input  logic                     d_word_i,
    input  logic [2:0]               d_funct3_i,
    input  logic [4:0]               d_rd_i,
    input  logic [ex_pkg::XLEN-1:0]  d_op1_i,
    input  logic [ex_pkg::XLEN-1:0]  d_op2_i,
    input  logic [ex_pkg::XLEN-1:0]  d_store_data_i,
    input  logic [ex_pkg::XLEN-1:0]  d_pc_i,
    input  logic [ex_pkg::XLEN-1:0]  d_offset_i,
    output logic                     valid_o,
    output logic                     rd_we_o,
    output logic [4:0]               rd_addr_o,
    output logic [ex_pkg::XLEN-1:0]  rd_data_o,
    output logic                     mem_ce_o,
    output logic                     mem_we_o,
    output logic [ex_pkg::XLEN-1:0]  mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]  mem_wdata_o,
    output logic                     jump_o,
    output logic [ex_pkg::XLEN-1:0]  jump_addr_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] agu_offset;
    logic [XLEN-1:0] agu_addr;
    logic [XLEN-1:0] agu_wdata;

    ex_alu u_alu (
        .op_i     (d_alu_op_i),
        .word_i   (d_word_i),
        .a_i      (d_op1_i),
        .b_i      (d_op2_i),
        .result_o (alu_result)
    );

    ex_branch_unit u_branch (
        .funct3_i (d_funct3_i),
        .a_i      (d_op1_i),
        .b_i      (d_op2_i),
        .pc_i     (d_pc_i),
        .offset_i (d_offset_i),
        .taken_o  (taken),
        .target_o (target)
    );

    // loads carry the i immediate in op2
    assign agu_offset = (d_unit_i == UNIT_LOAD) ? d_op2_i : d_offset_i;

    ex_mem_agu u_agu (
        .base_i       (d_op1_i),
        .offset_i     (agu_offset),
        .funct3_i     (d_funct3_i),
        .store_data_i (d_store_data_i),
        .addr_o       (agu_addr),
        .wdata_o      (agu_wdata)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            rd_we_o  <= 1'b0;
            mem_ce_o <= 1'b0;
            mem_we_o <= 1'b0;
            jump_o   <= 1'b0;
        end else begin
            valid_o  <= d_valid_i;
            rd_we_o  <= d_valid_i && (d_unit_i == UNIT_ALU || d_unit_i == UNIT_LOAD);
            mem_ce_o <= d_valid_i && (d_unit_i == UNIT_LOAD || d_unit_i == UNIT_STORE);
            mem_we_o <= d_valid_i && (d_unit_i == UNIT_STORE);
            jump_o   <= d_valid_i && (d_unit_i == UNIT_BRANCH) && taken;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_o   <= d_rd_i;
        rd_data_o   <= (d_unit_i == UNIT_ALU) ? alu_result : '0; // loads return 0 here
        mem_addr_o  <= agu_addr;
        mem_wdata_o <= agu_wdata;
        jump_addr_o <= (d_unit_i == UNIT_BRANCH) ? target : '0;
    end

endmodule

`default_nettype wire

//--- hw/ex_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute top: decode stage feeding execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     valid_i,
    input  logic [ex_pkg::ILEN-1:0]  inst_i,
    input  logic [ex_pkg::XLEN-1:0]  pc_i,
    input  logic [ex_pkg::XLEN-1:0]  op1_i,
    input  logic [ex_pkg::XLEN-1:0]  op2_i,       // rs2 or i immediate
    input  logic [ex_pkg::XLEN-1:0]  rs2_data_i,
    output logic                     valid_o,
    output logic                     rd_we_o,
    output logic [4:0]               rd_addr_o,
    output logic [ex_pkg::XLEN-1:0]  rd_data_o,
    output logic                     mem_ce_o,
    output logic                     mem_we_o,
    output logic [ex_pkg::XLEN-1:0]  mem_addr_o,
    output logic [ex_pkg::XLEN-1:0]  mem_wdata_o,
    output logic                     jump_o,
    output logic [ex_pkg::XLEN-1:0]  jump_addr_o
);
    import ex_pkg::*;

    logic            d_valid;
    unit_e           d_unit;
    alu_op_e         d_alu_op;
    logic            d_word;
    logic [2:0]      d_funct3;
    logic [4:0]      d_rd;
    logic [XLEN-1:0] d_op1;
    logic [XLEN-1:0] d_op2;
    logic [XLEN-1:0] d_store_data;
    logic [XLEN-1:0] d_pc;
    logic [XLEN-1:0] d_offset;

    ex_decode u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .rs2_data_i     (rs2_data_i),
        .d_valid_o      (d_valid),
        .d_unit_o       (d_unit),
        .d_alu_op_o     (d_alu_op),
        .d_word_o       (d_word),
        .d_funct3_o     (d_funct3),
        .d_rd_o         (d_rd),
        .d_op1_o        (d_op1),
        .d_op2_o        (d_op2),
        .d_store_data_o (d_store_data),
        .d_pc_o         (d_pc),
        .d_offset_o     (d_offset)
    );

    ex_execute u_execute (
        .clk            (clk),
        .reset_i        (reset_i),
        .d_valid_i      (d_valid),
        .d_unit_i       (d_unit),
        .d_alu_op_i     (d_alu_op),
        .d_word_i       (d_word),
        .d_funct3_i     (d_funct3),
        .d_rd_i         (d_rd),
        .d_op1_i        (d_op1),
        .d_op2_i        (d_op2),
        .d_store_data_i (d_store_data),
        .d_pc_i         (d_pc),
        .d_offset_i     (d_offset),
        .valid_o        (valid_o),
        .rd_we_o        (rd_we_o),
        .rd_addr_o      (rd_addr_o),
        .rd_data_o      (rd_data_o),
        .mem_ce_o       (mem_ce_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .jump_o         (jump_o),
        .jump_addr_o    (jump_addr_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_ex_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the execute stage top: replays the pattern
// file, checks results in order and per-record latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;
    import ex_pkg::*;

    localparam int NREC   = 40;
    localparam int REC_W  = 10;            // words per record
    localparam int WD_CYC = NREC * 3 + 50;

    logic            clk = 1'b0;
    logic            reset_i;
    logic            valid_i;
    logic [ILEN-1:0] inst_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] op1_i;
    logic [XLEN-1:0] op2_i;
    logic [XLEN-1:0] rs2_data_i;
    logic            valid_o;
    logic            rd_we_o;
    logic [4:0]      rd_addr_o;
    logic [XLEN-1:0] rd_data_o;
    logic            mem_ce_o;
    logic            mem_we_o;
    logic [XLEN-1:0] mem_addr_o;
    logic [XLEN-1:0] mem_wdata_o;
    logic            jump_o;
    logic [XLEN-1:0] jump_addr_o;

    logic [63:0] pat [0:NREC*REC_W-1];
    int          idx_q[$];  // records in flight
    int          due_q[$];  // cycle each one should come out
    int          cyc = 0;
    int          mismatches = 0;
    int          other_errs = 0;
    logic [31:0] rng;

    ex_top DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .rs2_data_i  (rs2_data_i),
        .valid_o     (valid_o),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .mem_ce_o    (mem_ce_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic apply_record(input int k);
        int b;
        b          = k * REC_W;
        valid_i    = 1'b1;
        inst_i     = pat[b][ILEN-1:0];
        pc_i       = pat[b+1];
        op1_i      = pat[b+2];
        op2_i      = pat[b+3];
        rs2_data_i = pat[b+4];
    endtask

    task automatic show_mismatch(input int k, input string field,
                                 input logic [63:0] got, input logic [63:0] exp);
        $display("Mismatch at %0t ns: record %0d %s got %h expected %h",
                 $time, k, field, got, exp);
        mismatches++;
    endtask

    // ctl word: [12:8] rd, [3] rd_we, [2] mem_ce, [1] mem_we, [0] jump
    task automatic check_outputs(input int k);
        int          b;
        logic [63:0] ctl;
        b   = k * REC_W;
        ctl = pat[b+5];
        if (rd_we_o !== ctl[3])
            show_mismatch(k, "rd_we_o", rd_we_o, ctl[3]);
        if (mem_ce_o !== ctl[2])
            show_mismatch(k, "mem_ce_o", mem_ce_o, ctl[2]);
        if (mem_we_o !== ctl[1])
            show_mismatch(k, "mem_we_o", mem_we_o, ctl[1]);
        if (jump_o !== ctl[0])
            show_mismatch(k, "jump_o", jump_o, ctl[0]);
        if (ctl[3] && rd_addr_o !== ctl[12:8])
            show_mismatch(k, "rd_addr_o", rd_addr_o, ctl[12:8]);
        if (ctl[3] && rd_data_o !== pat[b+6])
            show_mismatch(k, "rd_data_o", rd_data_o, pat[b+6]);
        if (ctl[2] && mem_addr_o !== pat[b+7])
            show_mismatch(k, "mem_addr_o", mem_addr_o, pat[b+7]);
        if (ctl[1] && mem_wdata_o !== pat[b+8])
            show_mismatch(k, "mem_wdata_o", mem_wdata_o, pat[b+8]);
        if (ctl[0] && jump_addr_o !== pat[b+9])
            show_mismatch(k, "jump_addr_o", jump_addr_o, pat[b+9]);
    endtask

    // outputs settle after the rising edge, sample mid-cycle
    always @(negedge clk) begin
        while (due_q.size() != 0 && due_q[0] < cyc) begin
            $display("record %0d gave no output in cycle %0d", idx_q[0], due_q[0]);
            other_errs++;
            idx_q.delete(0);
            due_q.delete(0);
        end
        if (valid_o === 1'b1) begin
            if (idx_q.size() == 0) begin
                $display("valid_o high at %0t ns with no instruction in flight", $time);
                other_errs++;
            end else begin
                if (due_q[0] != cyc) begin
                    $display("record %0d came out in cycle %0d instead of cycle %0d",
                             idx_q[0], cyc, due_q[0]);
                    other_errs++;
                end
                check_outputs(idx_q[0]);
                idx_q.delete(0);
                due_q.delete(0);
            end
        end else if ({valid_o, rd_we_o, mem_ce_o, mem_we_o, jump_o} !== 5'b0) begin
            $display("Mismatch at %0t ns: valid and controls %b expected 00000",
                     $time, {valid_o, rd_we_o, mem_ce_o, mem_we_o, jump_o});
            mismatches++;
        end
    end

    initial begin
        int k;
        reset_i    = 1'b1;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        op1_i      = '0;
        op2_i      = '0;
        rs2_data_i = '0;
        rng        = 32'h7689;
        $readmemh("dv/ex_patterns.mem", pat);
        if (^pat[0] === 1'bx) begin
            $display("could not read the pattern file dv/ex_patterns.mem");
            other_errs++;
        end
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (4) @(posedge clk); // idle after reset
        #1;
        for (k = 0; k < NREC; k++) begin
            rng = lcg_next(rng);
            if (rng[17:16] == 2'b00) begin
                valid_i = 1'b0; // bubble
                @(posedge clk);
                #1;
            end
            apply_record(k);
            idx_q.push_back(k);
            due_q.push_back(cyc + 2); // two register stages
            @(posedge clk);
            #1;
        end
        valid_i = 1'b0;
        while (idx_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WD_CYC);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ex_patterns.mem
// inst pc op1 op2 rs2_data ctl rd_data mem_addr mem_wdata jump_addr
// ctl: [12:8] rd, [3] rd_we, [2] mem_ce, [1] mem_we, [0] jump
002081b3 0 7fffffffffffffff 1 0 0308 8000000000000000 0 0 0 // add
40208233 0 5 7 0 0408 fffffffffffffffe 0 0 0 // sub
002092b3 0 1 43 0 0508 8 0 0 0 // sll
0020a333 0 ffffffffffffffff 1 0 0608 1 0 0 0 // slt
0020b3b3 0 ffffffffffffffff 1 0 0708 0 0 0 0 // sltu
0020c433 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0808 f0f0f0f0f0f0f0f0 0 0 0 // xor
0020d4b3 0 8000000000000000 4 0 0908 0800000000000000 0 0 0 // srl
4020d533 0 8000000000000000 4 0 0a08 f800000000000000 0 0 0 // sra
fff08693 0 100 ffffffffffffffff 0 0d08 ff 0 0 0 // addi -1
fff0a713 0 fffffffffffffffe ffffffffffffffff 0 0e08 1 0 0 0 // slti
43f0d793 0 8000000000000000 43f 0 0f08 ffffffffffffffff 0 0 0 // srai 63
02409813 0 3 24 0 1008 0000003000000000 0 0 0 // slli 36
002088bb 0 7fffffff 1 0 1108 ffffffff80000000 0 0 0 // addw
4020893b 0 1234567800000000 1 0 1208 ffffffffffffffff 0 0 0 // subw
002099bb 0 1 3f 0 1308 ffffffff80000000 0 0 0 // sllw
0020da3b 0 ffffffff80000000 4 0 1408 8000000 0 0 0 // srlw
4020dabb 0 80000000 4 0 1508 fffffffff8000000 0 0 0 // sraw
01008b1b 0 7ffffff0 10 0 1608 ffffffff80000000 0 0 0 // addiw
00809b9b 0 ffffff 8 0 1708 ffffffffffffff00 0 0 0 // slliw
0010dc1b 0 fffffffe 1 0 1808 7fffffff 0 0 0 // srliw
41f0dc9b 0 80000000 41f 0 1908 ffffffffffffffff 0 0 0 // sraiw
00208863 80000100 5 5 0 0001 0 0 0 80000110 // beq taken
00208863 80000100 5 6 0 0000 0 0 0 0 // beq
fe209ce3 80000100 5 6 0 0001 0 0 0 800000f8 // bne taken, back
00209863 80000100 7 7 0 0000 0 0 0 0 // bne
0020c863 80000100 ffffffffffffffff 1 0 0001 0 0 0 80000110 // blt taken
0020c863 80000100 1 ffffffffffffffff 0 0000 0 0 0 0 // blt
fe20dce3 80000100 1 ffffffffffffffff 0 0001 0 0 0 800000f8 // bge taken, back
0020d863 80000100 ffffffffffffffff 1 0 0000 0 0 0 0 // bge
0020e863 80000100 1 ffffffffffffffff 0 0001 0 0 0 80000110 // bltu taken
0020e863 80000100 ffffffffffffffff 1 0 0000 0 0 0 0 // bltu
fe20fce3 80000100 ffffffffffffffff 1 0 0001 0 0 0 800000f8 // bgeu taken, back
0020f863 80000100 1 ffffffffffffffff 0 0000 0 0 0 0 // bgeu
ff00bd03 0 80001000 fffffffffffffff0 0 1a0c 0 80000ff0 0 0 // ld -16
00208423 0 80002000 1122334455667788 1122334455667788 0006 0 80002008 88 0 // sb
00209423 0 80002000 1122334455667788 1122334455667788 0006 0 80002008 7788 0 // sh
fe20ae23 0 80002000 1122334455667788 1122334455667788 0006 0 80001ffc 55667788 0 // sw -4
0020b423 0 80002000 1122334455667788 1122334455667788 0006 0 80002008 1122334455667788 0 // sd
022081b3 0 1 2 0 0000 0 0 0 0 // mul, no m extension
0ff0000f 0 0 0 0 0000 0 0 0 0 // fence, unknown here

//--- all.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_mem_agu.sv
hw/ex_decode.sv
hw/ex_execute.sv
hw/ex_top.sv
dv/tb_ex_top.sv

//--- Bender.yml
package:
  name: rv64i_ex_stage

sources:
  - files:
      - hw/ex_pkg.sv
      - hw/ex_alu.sv
      - hw/ex_branch_unit.sv
      - hw/ex_mem_agu.sv
      - hw/ex_decode.sv
      - hw/ex_execute.sv
      - hw/ex_top.sv

  - target: test
    files:
      - dv/tb_ex_top.sv
